//--- lau_defines.svh
/*
 * adder unit constants
 * word width, result FIFO depth, bus width and register map
 */
`ifndef LAU_DEFINES_SVH
`define LAU_DEFINES_SVH

`define LAU_WIDTH      16   // operand and sum width
`define LAU_FIFO_DEPTH 4    // result entries, power of two
`define LAU_DATA_W     32   // wishbone data width

// word addresses, 2-bit adr
`define LAU_ADR_A      2'd0
`define LAU_ADR_B      2'd1
`define LAU_ADR_RESULT 2'd2
`define LAU_ADR_STATUS 2'd3

`endif

//--- lau_pkg.sv
/*
 * adder unit package
 * speed selection, log2 helper and the result FIFO entry
 */
`include "lau_defines.svh"

package lau_pkg;

	// floor(log2(n)), n > 0
	function automatic int log2floor(input int n);
		int m;
		int p;
		m = -1;
		p = 1;
		while (p <= n) begin
			m = m + 1;
			p = p * 2;
		end
		return m;
	endfunction

	typedef enum logic [1:0] {
		SLOW   = 2'b00,  // serial prefix / ripple
		MEDIUM = 2'b01,  // brent-kung
		FAST   = 2'b10   // sklansky
	} speed_e;

	// carry on top so the packed layout is {carry, sum}
	typedef struct packed {
		logic                  carry;
		logic [`LAU_WIDTH-1:0] sum;
	} result_t;

endpackage

//--- prefix_and_or.sv
/*
 * generate/propagate prefix tree
 * serial, Brent-Kung or Sklansky structure picked by speed
 */
`timescale 1ns/1ps

module prefix_and_or #(
	parameter int              width = 8,             // word width
	parameter lau_pkg::speed_e speed = lau_pkg::FAST  // tree structure
) (
	input  logic [width-1:0] gi,  // bit generate
	input  logic [width-1:0] pi,  // bit propagate
	output logic [width-1:0] go,  // group generate, bit 0 up to i
	output logic [width-1:0] po   // group propagate, bit 0 up to i
);
	import lau_pkg::*;

	localparam int n = width;
	localparam int m = $clog2(width);  // tree depth

	if (speed == FAST) begin : g_sklansky
		logic [m:0][n-1:0] gt, pt;  // per-level gen/prop
		assign gt[0] = gi;
		assign pt[0] = pi;
		for (genvar l = 1; l <= m; l++) begin : g_level
			for (genvar j = 0; j < n; j++) begin : g_bit
				if ((j >> (l-1)) % 2 == 1) begin : g_black
					// last bit of the lower half block
					localparam int src = ((j >> (l-1)) << (l-1)) - 1;
					assign gt[l][j] = gt[l-1][j] | (pt[l-1][j] & gt[l-1][src]);
					assign pt[l][j] = pt[l-1][j] & pt[l-1][src];
				end else begin : g_white
					assign gt[l][j] = gt[l-1][j];  // pass through
					assign pt[l][j] = pt[l-1][j];
				end
			end
		end
		assign go = gt[m];
		assign po = pt[m];
	end else if (speed == MEDIUM) begin : g_brent_kung
		logic [2*m-1:0][n-1:0] gt, pt;  // up-sweep then down-sweep levels
		assign gt[0] = gi;
		assign pt[0] = pi;
		// up-sweep, combine at the top of each 2**l block
		for (genvar l = 1; l <= m; l++) begin : g_up
			for (genvar j = 0; j < n; j++) begin : g_bit
				if ((j + 1) % (2 ** l) == 0) begin : g_black
					assign gt[l][j] = gt[l-1][j] | (pt[l-1][j] & gt[l-1][j - 2**(l-1)]);
					assign pt[l][j] = pt[l-1][j] & pt[l-1][j - 2**(l-1)];
				end else begin : g_white
					assign gt[l][j] = gt[l-1][j];
					assign pt[l][j] = pt[l-1][j];
				end
			end
		end
		// down-sweep fills the mid points, block size shrinks per level
		for (genvar l = m + 1; l < 2*m; l++) begin : g_down
			localparam int d = 2*m - l;
			for (genvar j = 0; j < n; j++) begin : g_bit
				if (((j + 1) % (2 ** d) == 2 ** (d-1)) && (j >= 2 ** d)) begin : g_black
					assign gt[l][j] = gt[l-1][j] | (pt[l-1][j] & gt[l-1][j - 2**(d-1)]);
					assign pt[l][j] = pt[l-1][j] & pt[l-1][j - 2**(d-1)];
				end else begin : g_white
					assign gt[l][j] = gt[l-1][j];
					assign pt[l][j] = pt[l-1][j];
				end
			end
		end
		assign go = gt[2*m-1];
		assign po = pt[2*m-1];
	end else begin : g_serial
		logic [n-1:0] gt, pt;  // one chain, n-1 levels deep
		assign gt[0] = gi[0];
		assign pt[0] = pi[0];
		for (genvar i = 1; i < n; i++) begin : g_bit
			assign gt[i] = gi[i] | (pi[i] & gt[i-1]);
			assign pt[i] = pi[i] & pt[i-1];
		end
		assign go = gt;
		assign po = pt;
	end

endmodule

//--- prefix_adder.sv
/*
 * binary adder with carry-out
 * ripple for SLOW, parallel-prefix carry lookahead otherwise
 */
`timescale 1ns/1ps

module prefix_adder #(
	parameter int              width = 8,
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	output logic [width-1:0] sum,
	output logic             carry  // carry out of the top bit
);
	import lau_pkg::*;

	if (speed == SLOW) begin : g_ripple
		logic [width:0] wide;  // sum with carry bit on top
		assign wide = {1'b0, a} + {1'b0, b};
		assign sum = wide[width-1:0];
		assign carry = wide[width];
	end else begin : g_prefix
		logic [width-1:0] gi, pi;  // prefix inputs
		logic [width-1:0] go;      // carry into bit i+1
		logic [width-1:0] pt;      // half sum, a xor b

		assign gi = a & b;
		assign pi = a | b;
		assign pt = ~gi & pi;

		prefix_and_or #(
			.width(width),
			.speed(speed)
		) u_prefix (
			.gi(gi),
			.pi(pi),
			.go(go),
			.po()  // group propagate not needed for plain add
		);

		assign sum = pt ^ {go[width-2:0], 1'b0};  // carry in to bit 0 is zero
		assign carry = go[width-1];
	end

endmodule

//--- operand_stage.sv
/*
 * operand stage
 * keeps operand A, adds B on arrival and hands the sum to the FIFO
 */
`timescale 1ns/1ps
`include "lau_defines.svh"

module operand_stage #(
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  load_a,     // write to A
	input  logic                  load_b,     // accepted write to B
	input  logic [`LAU_WIDTH-1:0] operand,    // bus write data
	output logic                  push,
	output lau_pkg::result_t      push_data
);
	logic [`LAU_WIDTH-1:0] opa;  // operand A
	logic [`LAU_WIDTH-1:0] sum;
	logic                  carry;

	always_ff @(posedge clk) begin
		if (rst) begin
			opa <= '0;  // B without A adds to zero
		end else if (load_a) begin
			opa <= operand;
		end
	end

	prefix_adder #(
		.width(`LAU_WIDTH),
		.speed(speed)
	) u_adder (
		.a    (opa),
		.b    (operand),  // B straight from the bus, never stored
		.sum  (sum),
		.carry(carry)
	);

	// entry goes into the FIFO at the end of the answer cycle
	assign push = load_b;
	assign push_data.sum = sum;
	assign push_data.carry = carry;

endmodule

//--- result_fifo.sv
/*
 * result FIFO
 * circular buffer of depth entries of any packed type
 */
`timescale 1ns/1ps

module result_fifo #(
	parameter type entry_t = logic,
	parameter int  depth   = 4  // power of two
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                push,
	input  entry_t                              push_data,
	input  logic                                pop,
	output entry_t                              head,  // oldest entry
	output logic                                empty,
	output logic                                full,
	output logic [lau_pkg::log2floor(depth):0] count
);
	import lau_pkg::*;

	localparam int aw = log2floor(depth);  // pointer width

	entry_t          mem [depth];
	logic [aw-1:0]   wr_ptr, rd_ptr;  // wrap on their own
	logic            do_push, do_pop;

	assign empty = (count == '0);
	assign full = (count == (aw+1)'(depth));
	assign do_push = push & ~full;  // drop push when full
	assign do_pop = pop & ~empty;   // drop pop when empty
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			// push and pop together leave count alone
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- bus_port.sv
/*
 * wishbone classic slave for the adder unit
 * one-cycle answer, err on B write into a full FIFO, result pop on read
 */
`timescale 1ns/1ps
`include "lau_defines.svh"

module bus_port (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic                                          cyc,
	input  logic                                          stb,
	input  logic                                          we,
	input  logic [1:0]                                    adr,
	input  logic [`LAU_DATA_W-1:0]                        dat_w,
	output logic [`LAU_DATA_W-1:0]                        dat_r,
	output logic                                          ack,
	output logic                                          err,
	output logic                                          load_a,
	output logic                                          load_b,
	output logic [`LAU_WIDTH-1:0]                         operand,
	input  lau_pkg::result_t                              head,
	input  logic                                          empty,
	input  logic                                          full,
	input  logic [lau_pkg::log2floor(`LAU_FIFO_DEPTH):0] count,
	output logic                                          pop
);
	import lau_pkg::*;

	localparam int cw = log2floor(`LAU_FIFO_DEPTH) + 1;  // count width

	logic                   req;  // new request this cycle
	logic                   wr_a, wr_b, rd_res, rd_stat;
	logic [`LAU_DATA_W-1:0] rd_word;

	// master still holds stb during the answer, don't answer twice
	assign req = cyc & stb & ~ack & ~err;
	assign wr_a = req & we & (adr == `LAU_ADR_A);
	assign wr_b = req & we & (adr == `LAU_ADR_B);
	assign rd_res = req & ~we & (adr == `LAU_ADR_RESULT);
	assign rd_stat = req & ~we & (adr == `LAU_ADR_STATUS);

	// read word, zero for A/B reads and when nothing is read
	always_comb begin
		rd_word = '0;
		if (rd_res && !empty) begin
			rd_word[`LAU_DATA_W-1] = 1'b1;          // valid
			rd_word[$bits(result_t)-1:0] = head;     // {carry, sum}
		end else if (rd_stat) begin
			rd_word[cw-1:0] = count;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
			err <= 1'b0;
			load_a <= 1'b0;
			load_b <= 1'b0;
			pop <= 1'b0;
			dat_r <= '0;
		end else begin
			ack <= req & ~(wr_b & full);
			err <= wr_b & full;  // no room, nothing pushed
			load_a <= wr_a;
			load_b <= wr_b & ~full;
			pop <= rd_res & ~empty;
			dat_r <= rd_word;
		end
	end

	always_ff @(posedge clk) begin
		if (req) operand <= dat_w[`LAU_WIDTH-1:0];  // lines up with load strobes
	end

endmodule

//--- adder_unit_top.sv
/*
 * adder unit top
 * bus port, operand stage and result FIFO
 */
`timescale 1ns/1ps
`include "lau_defines.svh"

module adder_unit_top #(
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  logic [1:0]             adr,
	input  logic [`LAU_DATA_W-1:0] dat_w,
	output logic [`LAU_DATA_W-1:0] dat_r,
	output logic                   ack,
	output logic                   err
);
	import lau_pkg::*;

	logic                                  load_a, load_b;
	logic [`LAU_WIDTH-1:0]                 operand;
	logic                                  push, pop;
	result_t                               push_data, head;
	logic                                  empty, full;
	logic [log2floor(`LAU_FIFO_DEPTH):0]   count;  // fill level

	bus_port u_bus_port (
		.clk    (clk),
		.rst    (rst),
		.cyc    (cyc),
		.stb    (stb),
		.we     (we),
		.adr    (adr),
		.dat_w  (dat_w),
		.dat_r  (dat_r),
		.ack    (ack),
		.err    (err),
		.load_a (load_a),
		.load_b (load_b),
		.operand(operand),
		.head   (head),
		.empty  (empty),
		.full   (full),
		.count  (count),
		.pop    (pop)
	);

	operand_stage #(
		.speed(speed)
	) u_operand_stage (
		.clk      (clk),
		.rst      (rst),
		.load_a   (load_a),
		.load_b   (load_b),
		.operand  (operand),
		.push     (push),
		.push_data(push_data)
	);

	result_fifo #(
		.entry_t(result_t),
		.depth  (`LAU_FIFO_DEPTH)
	) u_result_fifo (
		.clk      (clk),
		.rst      (rst),
		.push     (push),
		.push_data(push_data),
		.pop      (pop),
		.head     (head),
		.empty    (empty),
		.full     (full),
		.count    (count)
	);

endmodule

//--- tb_clock_gen.sv
/*
 * testbench clock and reset
 * 20 ns clock, reset held high for the first 2 rising edges
 */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;  // 20 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;  // released on the edge, no race with the DUT
	end

endmodule

//--- adder_unit_assert.sv
/*
 * bus and FIFO protocol assertions for the adder unit
 * bound into bus_port
 */
`timescale 1ns/1ps

module adder_unit_assert (
	input logic clk,
	input logic rst,
	input logic ack,
	input logic err,
	input logic pop,
	input logic empty
);
	int fails = 0;  // assertion failures so far

	// one answer kind at a time
	a_ack_err_excl: assert property (@(posedge clk) disable iff (rst) !(ack && err))
		else begin
			$error("ack and err high in the same cycle");
			fails++;
		end

	// answers are single-cycle pulses
	a_ack_one: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
		else begin
			$error("ack held longer than one cycle");
			fails++;
		end
	a_err_one: assert property (@(posedge clk) disable iff (rst) err |=> !err)
		else begin
			$error("err held longer than one cycle");
			fails++;
		end

	a_pop_nonempty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
		else begin
			$error("pop while result FIFO is empty");  // pop on empty would be dropped
			fails++;
		end

endmodule

//--- tb_adder_unit.sv
/*
 * adder unit testbench
 * table of operand pairs driven over wishbone, results and FIFO level checked
 */
`timescale 1ns/1ps
`include "lau_defines.svh"

module tb_adder_unit #(
	parameter int speed_sel = 2  // 0 slow, 1 medium, 2 fast
);
	import lau_pkg::*;

	localparam speed_e speed = speed_e'(speed_sel);
	localparam int cw = log2floor(`LAU_FIFO_DEPTH) + 1;  // count width
	localparam int n_vec = 20;    // table entries
	localparam int n_fixed = 8;   // edge values, rest is random
	localparam int limit = 40 * n_vec + 200;  // timeout in cycles

	logic                   clk, rst;
	logic                   cyc, stb, we;
	logic [1:0]             adr;
	logic [`LAU_DATA_W-1:0] dat_w, dat_r;
	logic                   ack, err;

	// stimulus and expected entries
	logic [`LAU_WIDTH-1:0] vec_a [n_vec];
	logic [`LAU_WIDTH-1:0] vec_b [n_vec];
	result_t               vec_exp [n_vec];

	int     res_errs, cnt_errs, flag_errs, asrt_errs;
	int     cycles;
	integer seed;

	tb_clock_gen u_clk (
		.clk(clk),
		.rst(rst)
	);

	adder_unit_top #(
		.speed(speed)
	) u_dut (
		.clk  (clk),
		.rst  (rst),
		.cyc  (cyc),
		.stb  (stb),
		.we   (we),
		.adr  (adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack  (ack),
		.err  (err)
	);

	bind bus_port adder_unit_assert u_assert (
		.clk  (clk),
		.rst  (rst),
		.ack  (ack),
		.err  (err),
		.pop  (pop),
		.empty(empty)
	);

	// plain integer add, bit 16 is the carry
	function automatic result_t expected_entry(input logic [`LAU_WIDTH-1:0] a,
			input logic [`LAU_WIDTH-1:0] b);
		int      total;
		result_t r;
		total = int'(a) + int'(b);
		r.sum = total[`LAU_WIDTH-1:0];
		r.carry = total[`LAU_WIDTH];  // 17th bit
		return r;
	endfunction

	task automatic check_result(input result_t got, input result_t exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s result sum=%h carry=%b, expected sum=%h carry=%b",
				$time, what, got.sum, got.carry, exp.sum, exp.carry);
			res_errs++;
		end
	endtask

	task automatic check_count(input logic [cw-1:0] got, input logic [cw-1:0] exp,
			input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s count %0d, expected %0d", $time, what, got, exp);
			cnt_errs++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
			flag_errs++;
		end
	endtask

	// one classic cycle, held until ack or err
	task automatic bus_cycle(input logic wr, input logic [1:0] a, input logic [31:0] wd,
			output logic [31:0] rd, output logic got_err);
		int waits;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= wr;
		adr <= a;
		dat_w <= wd;
		@(posedge clk);
		waits = 0;
		while (!(ack || err)) begin  // global counter catches a hang
			@(posedge clk);
			waits++;
		end
		if (waits != 1) begin
			$display("ERR %0t: answer %0d cycles after the request, expected 1",
				$time, waits);
			flag_errs++;
		end
		rd = dat_r;
		got_err = err;
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic write_reg(input logic [1:0] a, input logic [`LAU_WIDTH-1:0] v,
			input logic exp_err, input string what);
		logic [31:0] rd;
		logic        e;
		bus_cycle(1'b1, a, {16'h0, v}, rd, e);
		check_flag(e, exp_err, {what, " err"});
	endtask

	task automatic read_result(input result_t exp, input logic exp_valid, input string what);
		logic [31:0] rd;
		logic        e;
		result_t     got;
		bus_cycle(1'b0, `LAU_ADR_RESULT, 32'h0, rd, e);
		got.sum = rd[15:0];
		got.carry = rd[16];
		check_flag(e, 1'b0, {what, " read err"});
		check_flag(rd[31], exp_valid, {what, " valid"});
		check_flag(|rd[30:17], 1'b0, {what, " unused bits"});
		if (exp_valid) begin
			check_result(got, exp, what);
		end else begin
			check_result(got, result_t'('0), what);  // empty read gives an all-zero word
		end
	endtask

	task automatic read_status(input logic [cw-1:0] exp, input string what);
		logic [31:0] rd;
		logic        e;
		bus_cycle(1'b0, `LAU_ADR_STATUS, 32'h0, rd, e);
		check_flag(e, 1'b0, {what, " status err"});
		check_flag(|rd[31:cw], 1'b0, {what, " status upper bits"});
		check_count(rd[cw-1:0], exp, what);
	endtask

	initial begin
		cycles = 0;
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: test did not finish within %0d cycles", limit);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		logic [31:0] r;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 2'd0;
		dat_w = '0;
		res_errs = 0;
		cnt_errs = 0;
		flag_errs = 0;
		asrt_errs = 0;
		seed = 32'hc04a3043;

		// edge values
		vec_a[0] = 16'h0000;
		vec_b[0] = 16'h0000;
		vec_a[1] = 16'hffff;  // max carry out
		vec_b[1] = 16'hffff;
		vec_a[2] = 16'hffff;  // carry through every bit
		vec_b[2] = 16'h0001;
		vec_a[3] = 16'h000f;  // nibble 0 -> 1
		vec_b[3] = 16'h0001;
		vec_a[4] = 16'h0fff;  // across three nibbles
		vec_b[4] = 16'h0001;
		vec_a[5] = 16'haaaa;  // alternating, no carries
		vec_b[5] = 16'h5555;
		vec_a[6] = 16'h5555;
		vec_b[6] = 16'h5555;
		vec_a[7] = 16'h8000;  // carry only from the top
		vec_b[7] = 16'h8000;
		for (int i = n_fixed; i < n_vec; i++) begin
			r = $random(seed);
			vec_a[i] = r[15:0];
			vec_b[i] = r[31:16];
		end
		for (int i = 0; i < n_vec; i++) vec_exp[i] = expected_entry(vec_a[i], vec_b[i]);

		$display("speed %s, %0d table entries", speed.name(), n_vec);
		wait (rst == 1'b0);
		@(posedge clk);

		// reset state, B alone adds to A = 0
		read_status('0, "after reset");
		write_reg(`LAU_ADR_B, 16'h1234, 1'b0, "B without A");
		read_result(expected_entry(16'h0000, 16'h1234), 1'b1, "B without A");

		// empty FIFO read
		read_result(result_t'('0), 1'b0, "empty read");
		read_status('0, "after empty read");

		for (int i = 0; i < n_vec; i++) begin
			write_reg(`LAU_ADR_A, vec_a[i], 1'b0, $sformatf("vector %0d A", i));
			write_reg(`LAU_ADR_B, vec_b[i], 1'b0, $sformatf("vector %0d B", i));
			read_result(vec_exp[i], 1'b1, $sformatf("vector %0d", i));
		end

		// fill to depth, count rising
		for (int i = 0; i < `LAU_FIFO_DEPTH; i++) begin
			write_reg(`LAU_ADR_A, vec_a[n_fixed+i], 1'b0, $sformatf("fill %0d A", i));
			write_reg(`LAU_ADR_B, vec_b[n_fixed+i], 1'b0, $sformatf("fill %0d B", i));
			read_status(cw'(i + 1), $sformatf("fill %0d", i));
		end

		// one more B while full, err and no push
		write_reg(`LAU_ADR_A, vec_a[n_fixed+4], 1'b0, "full A");
		write_reg(`LAU_ADR_B, vec_b[n_fixed+4], 1'b1, "full B");
		read_status(cw'(`LAU_FIFO_DEPTH), "after full B");

		// drain oldest first
		for (int i = 0; i < `LAU_FIFO_DEPTH; i++) begin
			read_result(vec_exp[n_fixed+i], 1'b1, $sformatf("drain %0d", i));
			read_status(cw'(`LAU_FIFO_DEPTH - 1 - i), $sformatf("drain %0d", i));
		end

		asrt_errs = u_dut.u_bus_port.u_assert.fails;
		$display("errors: result %0d, count %0d, flag %0d, assertion %0d",
			res_errs, cnt_errs, flag_errs, asrt_errs);
		if (res_errs + cnt_errs + flag_errs + asrt_errs == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+.
lau_pkg.sv
prefix_and_or.sv
prefix_adder.sv
operand_stage.sv
result_fifo.sv
bus_port.sv
adder_unit_top.sv
tb_clock_gen.sv
adder_unit_assert.sv
tb_adder_unit.sv

//--- run.sh
#!/bin/sh
# build and run the adder unit testbench with Verilator, once per adder speed
set -e
cd "$(dirname "$0")"

for sel in 0 1 2; do
	verilator --binary --assert -Wno-fatal --top-module tb_adder_unit \
		-Gspeed_sel=$sel -f sources.f --Mdir obj_dir_$sel
	out=$(./obj_dir_$sel/Vtb_adder_unit)
	echo "$out"
	if ! echo "$out" | grep -qx "Simulation finished: PASS"; then
		echo "speed $sel failed"
		exit 1
	fi
done
